//--- common/capture_pkg.sv
//////////////////////////////////////////////////////////////////////
// capture datapath definitions
// sizes of channels, samples, stamps and banks, and the stored word
//////////////////////////////////////////////////////////////////////
`default_nettype none

package capture_pkg;

  localparam int CHANNELS        = 4;
  localparam int SAMPLE_WIDTH    = 16;
  localparam int STAMP_WIDTH     = 15;
  localparam int BANK_DEPTH      = 64;
  localparam int BANK_ADDR_WIDTH = 6;
  localparam int CHAN_WIDTH      = 2;

  // bit 31 picks the view
  typedef struct packed {
    logic                    tag;
    logic [STAMP_WIDTH-1:0]  unused;
    logic [SAMPLE_WIDTH-1:0] sample;
  } sample_view_t;

  // first word of a run, stamped with the sample count where it began
  typedef struct packed {
    logic                    tag;
    logic [STAMP_WIDTH-1:0]  stamp;
    logic [SAMPLE_WIDTH-1:0] sample;
  } stamp_view_t;

  typedef union packed {
    sample_view_t sample_view;
    stamp_view_t  stamp_view;
  } capture_word_t;

endpackage

`default_nettype wire

//--- common/capture_regs_pkg.sv
//////////////////////////////////////////////////////////////////////
// capture register map
// APB offsets and control/status bit positions
//////////////////////////////////////////////////////////////////////
`default_nettype none

package capture_regs_pkg;

  localparam int APB_ADDR_WIDTH = 8;

  localparam logic [APB_ADDR_WIDTH-1:0] ADDR_CTRL        = 8'h00;
  localparam logic [APB_ADDR_WIDTH-1:0] ADDR_STATUS      = 8'h04;
  localparam logic [APB_ADDR_WIDTH-1:0] ADDR_THRESH_BASE = 8'h10;

  // CTRL bits
  localparam int CTRL_START = 0;
  localparam int CTRL_STOP  = 1;

  // STATUS bits with one overflow bit per channel from OVERFLOW_LSB up
  localparam int STATUS_CAPTURING    = 0;
  localparam int STATUS_READING      = 1;
  localparam int STATUS_OVERFLOW_LSB = 4;

endpackage

`default_nettype wire

//--- common/capture_cfg_if.sv
//////////////////////////////////////////////////////////////////////
// capture configuration bus
// thresholds and start/stop pulses out, capture status back
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface capture_cfg_if;

  logic [capture_pkg::CHANNELS-1:0][capture_pkg::SAMPLE_WIDTH-1:0] threshold_high;
  logic [capture_pkg::CHANNELS-1:0][capture_pkg::SAMPLE_WIDTH-1:0] threshold_low;
  logic                                                            start;
  logic                                                            stop;

  // status driven by the buffer
  logic                          capturing;
  logic                          reading;
  logic [capture_pkg::CHANNELS-1:0] overflow;

  modport cfg (
    output threshold_high, threshold_low, start, stop,
    input  capturing, reading, overflow
  );

  modport user (
    input  threshold_high, threshold_low, start, stop,
    output capturing, reading, overflow
  );

endinterface

`default_nettype wire

//--- common/capture_wr_if.sv
//////////////////////////////////////////////////////////////////////
// capture write bus
// per-channel words from the discriminator into the bank memories
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface capture_wr_if;

  logic [capture_pkg::CHANNELS-1:0]                             wr_en;
  capture_pkg::capture_word_t [capture_pkg::CHANNELS-1:0]       wr_word;
  // empties every bank
  logic                                                         clear;
  logic                                                         active;

  modport writer (output wr_en, wr_word, clear, active);

  modport reader (input wr_en, wr_word, clear, active);

endinterface

`default_nettype wire

//--- verilog/capture_regs.sv
//////////////////////////////////////////////////////////////////////
// capture register block
// APB slave with threshold storage, start/stop pulses and status
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module capture_regs (
  input  wire                                        clk,
  input  wire                                        reset,
  input  wire                                        psel,
  input  wire                                        penable,
  input  wire                                        pwrite,
  input  wire [capture_regs_pkg::APB_ADDR_WIDTH-1:0] paddr,
  input  wire [31:0]                                 pwdata,
  output logic [31:0]                                prdata,
  output logic                                       pready,
  output logic                                       pslverr,
  capture_cfg_if.cfg                                 cfg
);

  logic                                        access;
  logic                                        wr_access;
  logic                                        is_ctrl;
  logic                                        is_status;
  logic                                        is_thresh;
  logic [capture_regs_pkg::APB_ADDR_WIDTH-1:0] thresh_offset;
  logic [capture_pkg::CHAN_WIDTH-1:0]          thresh_idx;
  logic [31:0]                                 status;

  assign access    = psel && penable;
  assign wr_access = access && pwrite;

  //////////////////////////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////////////////////////
  assign is_ctrl       = (paddr == capture_regs_pkg::ADDR_CTRL);
  assign is_status     = (paddr == capture_regs_pkg::ADDR_STATUS);
  assign thresh_offset = paddr - capture_regs_pkg::ADDR_THRESH_BASE;
  assign thresh_idx    = thresh_offset[capture_pkg::CHAN_WIDTH+1:2];
  assign is_thresh     = (paddr >= capture_regs_pkg::ADDR_THRESH_BASE) &&
                         (thresh_offset <
                          capture_regs_pkg::APB_ADDR_WIDTH'(4 * capture_pkg::CHANNELS)) &&
                         (paddr[1:0] == 2'b00);

  // every access finishes in its enable phase
  assign pready  = 1'b1;
  assign pslverr = access && !(is_ctrl || is_status || is_thresh);

  always_comb begin
    status                                      = '0;
    status[capture_regs_pkg::STATUS_CAPTURING]  = cfg.capturing;
    status[capture_regs_pkg::STATUS_READING]    = cfg.reading;
    status[capture_regs_pkg::STATUS_OVERFLOW_LSB +: capture_pkg::CHANNELS] = cfg.overflow;
  end

  always_comb begin
    prdata = '0;
    if (is_status) begin
      prdata = status;
    end else if (is_thresh) begin
      prdata = {cfg.threshold_high[thresh_idx], cfg.threshold_low[thresh_idx]};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cfg.start          <= 1'b0;
      cfg.stop           <= 1'b0;
      cfg.threshold_high <= '0;
      cfg.threshold_low  <= '0;
    end else begin
      // a new capture can't begin until readout has drained
      cfg.start <= wr_access && is_ctrl && pwdata[capture_regs_pkg::CTRL_START] &&
                   !cfg.reading;
      cfg.stop  <= wr_access && is_ctrl && pwdata[capture_regs_pkg::CTRL_STOP];
      if (wr_access && is_thresh) begin
        cfg.threshold_high[thresh_idx] <= pwdata[31:16];
        cfg.threshold_low[thresh_idx]  <= pwdata[15:0];
      end
    end
  end

endmodule

`default_nettype wire

//--- sample_discriminator/sample_discriminator.sv
//////////////////////////////////////////////////////////////////////
// sample discriminator
// per-channel hysteresis on high/low thresholds; forms stamped and
// plain capture words for the bank memories
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sample_discriminator (
  input  wire                                                          clk,
  input  wire                                                          reset,
  input  wire [capture_pkg::CHANNELS-1:0][capture_pkg::SAMPLE_WIDTH-1:0] sample_data,
  input  wire                                                          sample_valid,
  capture_cfg_if.user                                                  cfg,
  capture_wr_if.writer                                                 wr
);

  logic                                                   active;
  logic                                                   take_sample;
  logic [capture_pkg::STAMP_WIDTH-1:0]                    sample_count;
  logic [capture_pkg::CHANNELS-1:0]                       is_high;
  logic [capture_pkg::CHANNELS-1:0]                       next_high;
  capture_pkg::capture_word_t [capture_pkg::CHANNELS-1:0] next_word;

  // samples in the start and stop pulse cycles are dropped
  assign take_sample = active && sample_valid && !cfg.start && !cfg.stop;

  assign wr.active = active;
  assign wr.clear  = cfg.start;

  //////////////////////////////////////////////////////////////////////
  // hysteresis and word formation
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    for (int c = 0; c < capture_pkg::CHANNELS; c++) begin
      if (sample_data[c] > cfg.threshold_high[c]) begin
        next_high[c] = 1'b1;
      end else if (sample_data[c] < cfg.threshold_low[c]) begin
        next_high[c] = 1'b0;
      end else begin
        next_high[c] = is_high[c];
      end

      next_word[c] = '0;
      // rising into a run stamps the count before it advances
      if (!is_high[c]) begin
        next_word[c].stamp_view.tag   = 1'b1;
        next_word[c].stamp_view.stamp = sample_count;
      end
      next_word[c].sample_view.sample = sample_data[c];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      active       <= 1'b0;
      sample_count <= '0;
      is_high      <= '0;
      wr.wr_en     <= '0;
    end else begin
      if (cfg.start) begin
        active       <= 1'b1;
        sample_count <= '0;
        is_high      <= '0;
      end else if (cfg.stop) begin
        active <= 1'b0;
      end else if (take_sample) begin
        sample_count <= sample_count + 1'b1;
        is_high      <= next_high;
      end
      wr.wr_en <= take_sample ? next_high : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (take_sample) begin
      wr.wr_word <= next_word;
    end
  end

endmodule

`default_nettype wire

//--- sample_buffer/sample_buffer.sv
//////////////////////////////////////////////////////////////////////
// sample buffer
// one bank per channel with fill count and overflow flag, and a
// readout sequencer streaming nonempty banks in channel order
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sample_buffer (
  input  wire                                clk,
  input  wire                                reset,
  capture_wr_if.reader                       wr,
  capture_cfg_if.user                        cfg,
  output capture_pkg::capture_word_t         out_data,
  output logic [capture_pkg::CHAN_WIDTH-1:0] out_channel,
  output logic                               out_last,
  output logic                               out_valid,
  input  wire                                out_ready
);

  capture_pkg::capture_word_t mem [capture_pkg::CHANNELS][capture_pkg::BANK_DEPTH];

  logic [capture_pkg::BANK_ADDR_WIDTH:0]   fill [capture_pkg::CHANNELS];
  logic [capture_pkg::CHANNELS-1:0]        full;
  logic [capture_pkg::CHANNELS-1:0]        nonempty;
  logic [capture_pkg::CHANNELS-1:0]        later;
  logic [capture_pkg::CHAN_WIDTH-1:0]      first_chan;
  logic [capture_pkg::CHAN_WIDTH-1:0]      next_chan;
  logic                                    reading;
  logic                                    seek;
  logic                                    pending;
  logic                                    load;
  logic                                    bank_end;
  logic [capture_pkg::CHAN_WIDTH-1:0]      rd_chan;
  logic [capture_pkg::BANK_ADDR_WIDTH-1:0] rd_addr;

  assign cfg.capturing = wr.active;
  assign cfg.reading   = reading;

  //////////////////////////////////////////////////////////////////////
  // bank writes
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    for (int c = 0; c < capture_pkg::CHANNELS; c++) begin
      full[c] = (fill[c] == (capture_pkg::BANK_ADDR_WIDTH + 1)'(capture_pkg::BANK_DEPTH));
    end
  end

  always_ff @(posedge clk) begin
    if (reset || wr.clear) begin
      for (int c = 0; c < capture_pkg::CHANNELS; c++) begin
        fill[c] <= '0;
      end
      cfg.overflow <= '0;
    end else begin
      for (int c = 0; c < capture_pkg::CHANNELS; c++) begin
        if (wr.wr_en[c]) begin
          if (full[c]) begin
            cfg.overflow[c] <= 1'b1;
          end else begin
            fill[c] <= fill[c] + 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int c = 0; c < capture_pkg::CHANNELS; c++) begin
      if (wr.wr_en[c] && !full[c]) begin
        mem[c][fill[c][capture_pkg::BANK_ADDR_WIDTH-1:0]] <= wr.wr_word[c];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // readout sequencer
  //////////////////////////////////////////////////////////////////////
  // lowest nonempty bank overall, and lowest one after the current bank
  always_comb begin
    first_chan = '0;
    next_chan  = '0;
    for (int c = capture_pkg::CHANNELS - 1; c >= 0; c--) begin
      nonempty[c] = (fill[c] != '0);
      later[c]    = nonempty[c] && (c > int'(rd_chan));
      if (nonempty[c]) begin
        first_chan = capture_pkg::CHAN_WIDTH'(c);
      end
      if (later[c]) begin
        next_chan = capture_pkg::CHAN_WIDTH'(c);
      end
    end
  end

  assign bank_end = ({1'b0, rd_addr} == fill[rd_chan] - 1'b1);
  assign load     = pending && (!out_valid || out_ready);

  always_ff @(posedge clk) begin
    if (reset) begin
      reading   <= 1'b0;
      seek      <= 1'b0;
      pending   <= 1'b0;
      out_valid <= 1'b0;
      rd_chan   <= '0;
      rd_addr   <= '0;
    end else begin
      if (cfg.stop && wr.active && !reading) begin
        reading <= 1'b1;
        seek    <= 1'b1;
      end
      // one cycle after stop, so the final bank write has landed
      if (seek) begin
        seek <= 1'b0;
        if (|nonempty) begin
          pending <= 1'b1;
          rd_chan <= first_chan;
          rd_addr <= '0;
        end else begin
          reading <= 1'b0;
        end
      end
      if (load) begin
        out_valid <= 1'b1;
        if (!bank_end) begin
          rd_addr <= rd_addr + 1'b1;
        end else if (|later) begin
          rd_chan <= next_chan;
          rd_addr <= '0;
        end else begin
          pending <= 1'b0;
        end
      end else if (out_valid && out_ready) begin
        out_valid <= 1'b0;
      end
      if (out_valid && out_ready && out_last) begin
        reading <= 1'b0;
      end
    end
  end

  // output stage holds while the consumer stalls
  always_ff @(posedge clk) begin
    if (load) begin
      out_data    <= mem[rd_chan][rd_addr];
      out_channel <= rd_chan;
      out_last    <= bank_end && !(|later);
    end
  end

endmodule

`default_nettype wire

//--- verilog/sparse_capture.sv
//////////////////////////////////////////////////////////////////////
// sparse capture top level
// APB registers, discriminator and banked buffer for four channels
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sparse_capture (
  input  wire                                                          clk,
  input  wire                                                          reset,
  // APB
  input  wire                                                          psel,
  input  wire                                                          penable,
  input  wire                                                          pwrite,
  input  wire [capture_regs_pkg::APB_ADDR_WIDTH-1:0]                   paddr,
  input  wire [31:0]                                                   pwdata,
  output logic [31:0]                                                  prdata,
  output logic                                                         pready,
  output logic                                                         pslverr,
  // samples in
  input  wire [capture_pkg::CHANNELS-1:0][capture_pkg::SAMPLE_WIDTH-1:0] sample_data,
  input  wire                                                          sample_valid,
  // readout stream
  output logic [31:0]                                                  out_data,
  output logic [capture_pkg::CHAN_WIDTH-1:0]                           out_channel,
  output logic                                                         out_last,
  output logic                                                         out_valid,
  input  wire                                                          out_ready
);

  capture_cfg_if cfg_bus ();
  capture_wr_if  wr_bus ();

  capture_regs u_capture_regs (
    .clk     (clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .cfg     (cfg_bus.cfg)
  );

  sample_discriminator u_sample_discriminator (
    .clk          (clk),
    .reset        (reset),
    .sample_data  (sample_data),
    .sample_valid (sample_valid),
    .cfg          (cfg_bus.user),
    .wr           (wr_bus.writer)
  );

  sample_buffer u_sample_buffer (
    .clk         (clk),
    .reset       (reset),
    .wr          (wr_bus.reader),
    .cfg         (cfg_bus.user),
    .out_data    (out_data),
    .out_channel (out_channel),
    .out_last    (out_last),
    .out_valid   (out_valid),
    .out_ready   (out_ready)
  );

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
//////////////////////////////////////////////////////////////////////
// testbench clock source with an 8 ns period
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk
);

  initial clk = 1'b0;

  // 4 ns per half period
  always #4 clk = ~clk;

endmodule

`default_nettype wire

//--- tb/sparse_capture_tb.sv
//////////////////////////////////////////////////////////////////////
// sparse capture testbench
// directed tests over APB and the readout stream, checked against a
// reference model of the hysteresis rule and the bank limit
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sparse_capture_tb;

  localparam int          CH            = capture_pkg::CHANNELS;
  localparam int          MAX_SAMPLES   = 80;
  localparam int          APB_TIMEOUT   = 20;
  localparam int          READOUT_POLLS = 1000;
  localparam logic [31:0] SEED          = 32'd96142;

  logic                                        clk;
  logic                                        reset;
  logic                                        psel;
  logic                                        penable;
  logic                                        pwrite;
  logic [capture_regs_pkg::APB_ADDR_WIDTH-1:0] paddr;
  logic [31:0]                                 pwdata;
  logic [31:0]                                 prdata;
  logic                                        pready;
  logic                                        pslverr;
  logic [CH-1:0][capture_pkg::SAMPLE_WIDTH-1:0] sample_data;
  logic                                        sample_valid;
  logic [31:0]                                 out_data;
  logic [capture_pkg::CHAN_WIDTH-1:0]          out_channel;
  logic                                        out_last;
  logic                                        out_valid;
  logic                                        out_ready = 1'b0;

  int          checks;
  int          errors;
  string       cur_test;
  logic        bp_mode;
  logic [31:0] rng_state;
  logic [31:0] ready_state = SEED;
  logic [31:0] hyst_state;

  logic [15:0] stim [MAX_SAMPLES][CH];
  logic [15:0] thr_hi [CH];
  logic [15:0] thr_lo [CH];

  // expected and received stream
  logic [31:0]                        exp_words[$];
  logic [capture_pkg::CHAN_WIDTH-1:0] exp_chan[$];
  logic [CH-1:0]                      exp_ovf;
  logic [31:0]                        got_words[$];
  logic [capture_pkg::CHAN_WIDTH-1:0] got_chan[$];
  logic                               got_last[$];

  logic                               hold_pending;
  logic [31:0]                        held_data;
  logic [capture_pkg::CHAN_WIDTH-1:0] held_chan;
  logic                               held_last;

  tb_clock u_tb_clock (.clk(clk));

  sparse_capture u_sparse_capture (
    .clk          (clk),
    .reset        (reset),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .sample_data  (sample_data),
    .sample_valid (sample_valid),
    .out_data     (out_data),
    .out_channel  (out_channel),
    .out_last     (out_last),
    .out_valid    (out_valid),
    .out_ready    (out_ready)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [15:0] rand16();
    rng_state = lcg_next(rng_state);
    return rng_state[31:16];
  endfunction

  task automatic check_value(input string test, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("FAIL %s %s: expected %h actual %h", test, what, expected, actual);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stream monitor and ready pattern
  //////////////////////////////////////////////////////////////////////
  // a stalled word has to stay put until it is taken
  always @(negedge clk) begin
    if (hold_pending) begin
      check_value(cur_test, "held out_valid", 32'h1, 32'(out_valid));
      check_value(cur_test, "held out_data", held_data, out_data);
      check_value(cur_test, "held out_channel", 32'(held_chan), 32'(out_channel));
      check_value(cur_test, "held out_last", 32'(held_last), 32'(out_last));
    end
    if (out_valid && out_ready) begin
      got_words.push_back(out_data);
      got_chan.push_back(out_channel);
      got_last.push_back(out_last);
    end
    hold_pending = out_valid && !out_ready;
    held_data    = out_data;
    held_chan    = out_channel;
    held_last    = out_last;
  end

  always @(posedge clk) begin
    if (bp_mode) begin
      ready_state = lcg_next(ready_state);
      out_ready <= ready_state[17];
    end else begin
      out_ready <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // APB driver
  //////////////////////////////////////////////////////////////////////
  task automatic apb_access(input logic write, input logic [7:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waited;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    waited = 0;
    while (!pready && waited < APB_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!pready) begin
      errors++;
      $display("ERROR: APB access to %h got no pready", addr);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                           output logic err);
    logic [31:0] unused_rdata;
    apb_access(1'b1, addr, data, unused_rdata, err);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic err);
    apb_access(1'b0, addr, 32'h0, data, err);
  endtask

  // poll STATUS until READING drops
  task automatic wait_readout(input string name);
    logic [31:0] rdata;
    logic        err;
    int          polls;
    polls = 0;
    rdata = 32'h1 << capture_regs_pkg::STATUS_READING;
    while (rdata[capture_regs_pkg::STATUS_READING] && polls < READOUT_POLLS) begin
      apb_read(capture_regs_pkg::ADDR_STATUS, rdata, err);
      polls++;
    end
    if (rdata[capture_regs_pkg::STATUS_READING]) begin
      errors++;
      $display("ERROR: %s readout still running after %0d status polls", name, polls);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////
  task automatic build_model(input int n);
    logic        hi;
    logic        nh;
    logic [15:0] s;
    int          kept;
    exp_words.delete();
    exp_chan.delete();
    exp_ovf = '0;
    for (int c = 0; c < CH; c++) begin
      hi   = 1'b0;
      kept = 0;
      for (int i = 0; i < n; i++) begin
        s = stim[i][c];
        if (s > thr_hi[c]) begin
          nh = 1'b1;
        end else if (s < thr_lo[c]) begin
          nh = 1'b0;
        end else begin
          nh = hi;
        end
        if (nh && kept == capture_pkg::BANK_DEPTH) begin
          exp_ovf[c] = 1'b1;
        end else if (nh) begin
          // first word of a run carries the sample count
          exp_words.push_back(hi ? {16'h0000, s} : {1'b1, 15'(i), s});
          exp_chan.push_back(capture_pkg::CHAN_WIDTH'(c));
          kept++;
        end
        hi = nh;
      end
    end
  endtask

  // one full capture from thresholds and start through readout and compare
  task automatic run_capture(input string name, input int n, input logic bp);
    logic [31:0] rdata;
    logic        err;
    int          last_idx;
    cur_test = name;
    build_model(n);
    for (int c = 0; c < CH; c++) begin
      apb_write(capture_regs_pkg::ADDR_THRESH_BASE + 8'(4 * c), {thr_hi[c], thr_lo[c]}, err);
    end
    got_words.delete();
    got_chan.delete();
    got_last.delete();
    apb_write(capture_regs_pkg::ADDR_CTRL, 32'h1 << capture_regs_pkg::CTRL_START, err);
    apb_read(capture_regs_pkg::ADDR_STATUS, rdata, err);
    check_value(name, "status while capturing", 32'h1 << capture_regs_pkg::STATUS_CAPTURING,
                rdata);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      for (int c = 0; c < CH; c++) begin
        sample_data[c] <= stim[i][c];
      end
      sample_valid <= 1'b1;
    end
    @(posedge clk);
    sample_valid <= 1'b0;
    bp_mode      <= bp;
    apb_write(capture_regs_pkg::ADDR_CTRL, 32'h1 << capture_regs_pkg::CTRL_STOP, err);
    wait_readout(name);
    bp_mode <= 1'b0;
    check_value(name, "word count", 32'(exp_words.size()), 32'(got_words.size()));
    last_idx = exp_words.size() - 1;
    for (int k = 0; k < exp_words.size() && k < got_words.size(); k++) begin
      check_value(name, "out_data", exp_words[k], got_words[k]);
      check_value(name, "out_channel", 32'(exp_chan[k]), 32'(got_chan[k]));
      check_value(name, "out_last", 32'(k == last_idx), 32'(got_last[k]));
    end
    apb_read(capture_regs_pkg::ADDR_STATUS, rdata, err);
    check_value(name, "status after readout",
                32'(exp_ovf) << capture_regs_pkg::STATUS_OVERFLOW_LSB, rdata);
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////
  task automatic registers_test();
    logic [31:0] rdata;
    logic [31:0] val [CH];
    logic        err;
    cur_test = "registers";
    apb_read(capture_regs_pkg::ADDR_STATUS, rdata, err);
    check_value("registers", "status after reset", 32'h0, rdata);
    check_value("registers", "status pslverr", 32'h0, 32'(err));
    for (int c = 0; c < CH; c++) begin
      val[c] = {rand16(), rand16()};
      apb_write(capture_regs_pkg::ADDR_THRESH_BASE + 8'(4 * c), val[c], err);
    end
    for (int c = 0; c < CH; c++) begin
      apb_read(capture_regs_pkg::ADDR_THRESH_BASE + 8'(4 * c), rdata, err);
      check_value("registers", "threshold readback", val[c], rdata);
      check_value("registers", "threshold pslverr", 32'h0, 32'(err));
    end
    // gap in the map, past the last threshold, and misaligned
    apb_write(8'h08, 32'hffff_ffff, err);
    check_value("registers", "pslverr at 0x08", 32'h1, 32'(err));
    apb_read(8'h20, rdata, err);
    check_value("registers", "pslverr at 0x20", 32'h1, 32'(err));
    apb_read(8'h12, rdata, err);
    check_value("registers", "pslverr at 0x12", 32'h1, 32'(err));
  endtask

  task automatic save_all_test();
    for (int c = 0; c < CH; c++) begin
      thr_hi[c] = 16'h0100;
      thr_lo[c] = 16'h0080;
    end
    for (int i = 0; i < 20; i++) begin
      for (int c = 0; c < CH; c++) begin
        stim[i][c] = 16'h0200 | rand16();
      end
    end
    run_capture("save_all", 20, 1'b0);
    if (got_words.size() > 0) begin
      check_value("save_all", "first stamp", {1'b1, 15'd0, stim[0][0]}, got_words[0]);
    end
  endtask

  // wide, narrow and zero gaps between the two thresholds
  task automatic make_hysteresis_stim();
    thr_hi[0] = 16'h9000;
    thr_lo[0] = 16'h7000;
    thr_hi[1] = 16'h8100;
    thr_lo[1] = 16'h7f00;
    thr_hi[2] = 16'hc000;
    thr_lo[2] = 16'h4000;
    thr_hi[3] = 16'h8000;
    thr_lo[3] = 16'h8000;
    for (int i = 0; i < 50; i++) begin
      for (int c = 0; c < CH; c++) begin
        stim[i][c] = rand16();
      end
    end
  endtask

  task automatic hysteresis_test();
    hyst_state = rng_state;
    make_hysteresis_stim();
    run_capture("hysteresis", 50, 1'b0);
  endtask

  task automatic nothing_saved_test();
    for (int c = 0; c < CH; c++) begin
      thr_hi[c] = 16'hf000;
      thr_lo[c] = 16'he000;
    end
    for (int i = 0; i < 30; i++) begin
      for (int c = 0; c < CH; c++) begin
        stim[i][c] = rand16() % 16'he000;
      end
    end
    run_capture("nothing_saved", 30, 1'b0);
  endtask

  task automatic overflow_test();
    for (int c = 0; c < CH; c++) begin
      thr_hi[c] = 16'h0010;
      thr_lo[c] = 16'h0008;
    end
    for (int i = 0; i < 70; i++) begin
      for (int c = 0; c < CH; c++) begin
        stim[i][c] = 16'h1000 | rand16();
      end
    end
    run_capture("overflow", 70, 1'b0);
  endtask

  // same samples as the hysteresis test with a consumer that stalls at random
  task automatic backpressure_test();
    rng_state = hyst_state;
    make_hysteresis_stim();
    run_capture("backpressure", 50, 1'b1);
  endtask

  initial begin
    checks       = 0;
    errors       = 0;
    cur_test     = "reset";
    bp_mode      = 1'b0;
    rng_state    = SEED;
    hyst_state   = SEED;
    hold_pending = 1'b0;
    reset        = 1'b1;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    sample_data  = '0;
    sample_valid = 1'b0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    registers_test();
    save_all_test();
    hysteresis_test();
    nothing_saved_test();
    overflow_test();
    backpressure_test();

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sparse_capture.f
common/capture_pkg.sv
common/capture_regs_pkg.sv
common/capture_cfg_if.sv
common/capture_wr_if.sv
verilog/capture_regs.sv
sample_discriminator/sample_discriminator.sv
sample_buffer/sample_buffer.sv
verilog/sparse_capture.sv
tb/tb_clock.sv
tb/sparse_capture_tb.sv

//--- Makefile
# Verilator build for the sparse capture testbench

TOOL       = verilator
TOP        = sparse_capture_tb
FILELIST   = sparse_capture.f
LINT_FLAGS = --lint-only --timing -Wall
SIM_FLAGS  = --binary --timing -Wno-fatal
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
